// ==== src.f ====
+incdir+rtl
rtl/wb_pkg.sv
rtl/wb_regfile.sv
rtl/wb_exception_unit.sv
rtl/wb_pc_sequencer.sv
rtl/wb_stage_top.sv
test/tb_wb_stage.sv

// ==== Makefile ====
# Verilator flow for the writeback stage testbench.
# Any variable below can be overridden on the command line.

VERILATOR  ?= verilator
TOP        ?= tb_wb_stage
RTL_TOP    ?= wb_stage_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The log decides the result, the exit code of the model does not.
run: build
	-$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Simulation failed" $(LOG); then \
		echo "Result: FAIL"; exit 1; \
	fi
	@if ! grep -q "Simulation passed" $(LOG); then \
		echo "Result: FAIL, no pass message in $(LOG)"; exit 1; \
	fi
	@echo "Result: PASS"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== test/tb_wb_stage.sv ====
// --------------------------------------------------
// Writeback stage testbench.
// Directed tests for PC sequencing, retire writes,
// load to PC, exception entry, shelving and restart.
// --------------------------------------------------

`include "wb_config.svh"

module tb_wb_stage
import wb_pkg::*;
();

// Far above the length of all tests together.
localparam int TIMEOUT_CYCLES = 400;

logic      i_clk = 1'b0;
logic      i_reset;
logic      i_code_stall;
logic      i_clear_from_alu;
word_t     i_pc_from_alu;
logic      i_clear_from_decode;
word_t     i_pc_from_decode;
logic      i_clear_from_icache;
logic      i_thumb;
word_t     i_pc_buf_ff;
retire_t   i_retire;
exc_t      i_exc;
phy_idx_t  i_rd_index_0;
phy_idx_t  i_rd_index_1;
word_t     o_rd_data_0;
word_t     o_rd_data_1;
word_t     o_pc;
word_t     o_pc_nxt;
cpsr_t     o_cpsr_nxt;
logic      o_clear_from_writeback;
logic      o_shelve;
logic      o_mask;

// Reference model of the PC pair and status.
word_t     exp_pc;
word_t     exp_pc_nxt;
cpsr_t     exp_cpsr;
// Last banked link and saved status.
word_t     banked_ret;
cpsr_t     banked_spsr;
int        cycle_count = 0;

wb_stage_top u_dut (
        .i_clk                  (i_clk),
        .i_reset                (i_reset),
        .i_code_stall           (i_code_stall),
        .i_clear_from_alu       (i_clear_from_alu),
        .i_pc_from_alu          (i_pc_from_alu),
        .i_clear_from_decode    (i_clear_from_decode),
        .i_pc_from_decode       (i_pc_from_decode),
        .i_clear_from_icache    (i_clear_from_icache),
        .i_thumb                (i_thumb),
        .i_pc_buf_ff            (i_pc_buf_ff),
        .i_retire               (i_retire),
        .i_exc                  (i_exc),
        .i_rd_index_0           (i_rd_index_0),
        .i_rd_index_1           (i_rd_index_1),
        .o_rd_data_0            (o_rd_data_0),
        .o_rd_data_1            (o_rd_data_1),
        .o_pc                   (o_pc),
        .o_pc_nxt               (o_pc_nxt),
        .o_cpsr_nxt             (o_cpsr_nxt),
        .o_clear_from_writeback (o_clear_from_writeback),
        .o_shelve               (o_shelve),
        .o_mask                 (o_mask)
);

always #50 i_clk = ~i_clk;

// --------------------------------------------------
// Reporting and compare tasks
// --------------------------------------------------

task automatic stop_run(input string why);
begin
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1, "Run stopped.");
end
endtask

task automatic check_word(input string name, input word_t expected, input word_t actual);
begin
        if (actual !== expected)
        begin
                stop_run($sformatf("CHECK FAILED %s expected %h actual %h",
                                   name, expected, actual));
        end
end
endtask

task automatic check_cpsr(input string name, input cpsr_t expected, input cpsr_t actual);
begin
        if (actual !== expected)
        begin
                stop_run($sformatf("CHECK FAILED %s expected %h actual %h",
                                   name, expected, actual));
        end
end
endtask

task automatic check_bit(input string name, input logic expected, input logic actual);
begin
        if (actual !== expected)
        begin
                stop_run($sformatf("CHECK FAILED %s expected %b actual %b",
                                   name, expected, actual));
        end
end
endtask

// Cycle limit.
always @(posedge i_clk)
begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
                stop_run("Timeout: the tests did not finish within the cycle limit.");
        end
end

// --------------------------------------------------
// Stimulus helpers
// --------------------------------------------------

// Inputs change on the rising edge, outputs are read on the falling one.
task automatic tick();
begin
        @(posedge i_clk);
end
endtask

task automatic settle();
begin
        @(negedge i_clk);
end
endtask

function automatic cpsr_t make_cpsr(input logic [3:0] nzcv, input logic irq_mask,
                                    input logic fiq_mask, input logic [4:0] mode);
        cpsr_t c;
begin
        c = '0;
        {c.n, c.z, c.c, c.v} = nzcv;
        c.i = irq_mask;
        c.f = fiq_mask;
        c.mode = mode;
        return c;
end
endfunction

function automatic wr_req_t make_wr(input phy_idx_t idx, input word_t data);
        wr_req_t w;
begin
        w.idx = idx;
        w.data = data;
        return w;
end
endfunction

task automatic drive_idle();
begin
        i_retire            <= '0;
        i_exc               <= '0;
        i_clear_from_alu    <= 1'b0;
        i_clear_from_decode <= 1'b0;
        i_clear_from_icache <= 1'b0;
        i_code_stall        <= 1'b0;
        i_thumb             <= 1'b0;
end
endtask

task automatic present_retire(input wr_req_t alu_wr, input cpsr_t flags,
                              input logic load, input wr_req_t mem_wr);
        retire_t r;
begin
        r.valid    = 1'b1;
        r.alu_wr   = alu_wr;
        r.flags    = flags;
        r.mem_load = load;
        r.mem_wr   = mem_wr;
        i_retire <= r;
end
endtask

// Normal step of the PC pair.
task automatic expect_advance(input string name, input word_t step);
begin
        exp_pc     = exp_pc_nxt;
        exp_pc_nxt = exp_pc_nxt + step;
        check_word({name, " o_pc_nxt"}, exp_pc_nxt, o_pc_nxt);
        check_word({name, " o_pc"}, exp_pc, o_pc);
        check_bit({name, " o_mask"}, 1'b0, o_mask);
end
endtask

// Redirect taken, bit 0 always clear.
task automatic expect_jump(input string name, input word_t target);
begin
        exp_pc     = exp_pc_nxt;
        exp_pc_nxt = {target[31:1], 1'b0};
        check_word({name, " o_pc_nxt"}, exp_pc_nxt, o_pc_nxt);
        check_word({name, " o_pc"}, exp_pc, o_pc);
        check_bit({name, " o_mask"}, 1'b1, o_mask);
end
endtask

task automatic expect_hold(input string name, input logic shelved);
begin
        check_word({name, " o_pc_nxt"}, exp_pc_nxt, o_pc_nxt);
        check_word({name, " o_pc"}, exp_pc, o_pc);
        check_bit({name, " o_shelve"}, shelved, o_shelve);
        check_bit({name, " o_mask"}, 1'b0, o_mask);
end
endtask

// --------------------------------------------------
// Tests
// --------------------------------------------------

task automatic test_reset_advance();
begin
        exp_pc     = '0;
        exp_pc_nxt = '0;
        exp_cpsr   = make_cpsr(4'b0000, 1'b1, 1'b1, `WB_MODE_SVC);
        settle();
        expect_hold("reset", 1'b0);
        check_cpsr("reset o_cpsr_nxt", exp_cpsr, o_cpsr_nxt);
        repeat (3)
        begin
                tick();
                settle();
                expect_advance("arm advance", 32'd4);
        end
        tick();
        i_thumb <= 1'b1;
        settle();
        expect_advance("arm advance", 32'd4);
        repeat (3)
        begin
                tick();
                settle();
                expect_advance("thumb advance", 32'd2);
        end
        tick();
        i_thumb <= 1'b0;
        settle();
        expect_advance("thumb advance", 32'd2);
end
endtask

task automatic test_retire();
        cpsr_t flags_a;
        cpsr_t flags_b;
begin
        flags_a = make_cpsr(4'b1010, 1'b0, 1'b0, `WB_MODE_SVC);
        flags_b = make_cpsr(4'b0101, 1'b0, 1'b0, `WB_MODE_SVC);
        tick();
        present_retire(make_wr(6'd1, 32'h1111_0001), flags_a, 1'b1,
                       make_wr(6'd2, 32'h2222_0002));
        i_rd_index_0 <= 6'd1;
        i_rd_index_1 <= 6'd2;
        settle();
        expect_advance("retire load", 32'd4);
        check_cpsr("retire load o_cpsr_nxt", flags_a, o_cpsr_nxt);
        check_bit("retire load o_clear_from_writeback", 1'b0, o_clear_from_writeback);
        tick();
        drive_idle();
        settle();
        expect_advance("retire load", 32'd4);
        check_word("retire load alu write", 32'h1111_0001, o_rd_data_0);
        check_word("retire load mem write", 32'h2222_0002, o_rd_data_1);
        check_cpsr("retire load held cpsr", flags_a, o_cpsr_nxt);
        // Memory port is ignored without a load.
        tick();
        present_retire(make_wr(6'd3, 32'h3333_0003), flags_b, 1'b0,
                       make_wr(6'd2, 32'hDEAD_BEEF));
        i_rd_index_0 <= 6'd3;
        settle();
        expect_advance("retire alu", 32'd4);
        check_cpsr("retire alu o_cpsr_nxt", flags_b, o_cpsr_nxt);
        tick();
        drive_idle();
        settle();
        expect_advance("retire alu", 32'd4);
        check_word("retire alu write", 32'h3333_0003, o_rd_data_0);
        check_word("retire alu mem kept", 32'h2222_0002, o_rd_data_1);
        exp_cpsr = flags_b;
end
endtask

task automatic test_load_pc();
begin
        tick();
        present_retire(make_wr(`WB_PHY_RAZ, 32'hFFFF_FFFF), exp_cpsr, 1'b1,
                       make_wr(`WB_PHY_PC, 32'h0000_0201));
        i_rd_index_0 <= `WB_PHY_PC;
        settle();
        expect_advance("load pc", 32'd4);
        check_bit("load pc o_clear_from_writeback", 1'b1, o_clear_from_writeback);
        tick();
        drive_idle();
        settle();
        expect_jump("load pc", 32'h0000_0201);
        check_word("load pc register", 32'h0000_0201, o_rd_data_0);
        check_bit("load pc clear drop", 1'b0, o_clear_from_writeback);
        tick();
        settle();
        expect_advance("after load pc", 32'd4);
end
endtask

// One exception request, checked over two cycles.
task automatic take_exception(input string name, input exc_t req, input logic [4:0] mode,
                              input phy_idx_t r14, input phy_idx_t spsr, input word_t vec,
                              input logic set_f, input word_t pc_buf);
        cpsr_t old_cpsr;
        cpsr_t new_cpsr;
begin
        old_cpsr      = exp_cpsr;
        new_cpsr      = old_cpsr;
        new_cpsr.mode = mode;
        new_cpsr.i    = 1'b1;
        new_cpsr.t    = 1'b0;
        new_cpsr.f    = old_cpsr.f | set_f;
        tick();
        i_exc       <= req;
        i_pc_buf_ff <= pc_buf;
        settle();
        expect_advance(name, 32'd4);
        check_bit({name, " o_clear_from_writeback"}, 1'b1, o_clear_from_writeback);
        check_cpsr({name, " o_cpsr_nxt"}, new_cpsr, o_cpsr_nxt);
        tick();
        drive_idle();
        i_rd_index_0 <= r14;
        i_rd_index_1 <= spsr;
        settle();
        expect_jump(name, vec);
        check_word({name, " banked r14"}, pc_buf, o_rd_data_0);
        check_word({name, " banked spsr"}, word_t'(old_cpsr), o_rd_data_1);
        check_cpsr({name, " cpsr held"}, new_cpsr, o_cpsr_nxt);
        exp_cpsr    = new_cpsr;
        banked_ret  = pc_buf;
        banked_spsr = old_cpsr;
end
endtask

task automatic test_exceptions();
begin
        // Request bits are restart, dabt, fiq, irq, swi, und.
        take_exception("und", exc_t'(6'b000001), `WB_MODE_UND, `WB_PHY_UND_R14,
                       `WB_PHY_UND_SPSR, `WB_VEC_UND, 1'b0, 32'h0000_0108);
        take_exception("swi", exc_t'(6'b000010), `WB_MODE_SVC, `WB_PHY_SVC_R14,
                       `WB_PHY_SVC_SPSR, `WB_VEC_SWI, 1'b0, 32'h0000_0208);
        take_exception("irq", exc_t'(6'b000100), `WB_MODE_IRQ, `WB_PHY_IRQ_R14,
                       `WB_PHY_IRQ_SPSR, `WB_VEC_IRQ, 1'b0, 32'h0000_0308);
        take_exception("fiq", exc_t'(6'b001000), `WB_MODE_FIQ, `WB_PHY_FIQ_R14,
                       `WB_PHY_FIQ_SPSR, `WB_VEC_FIQ, 1'b1, 32'h0000_0408);
        take_exception("dabt", exc_t'(6'b010000), `WB_MODE_ABT, `WB_PHY_ABT_R14,
                       `WB_PHY_ABT_SPSR, `WB_VEC_DABT, 1'b0, 32'h0000_0508);
        take_exception("fiq over irq", exc_t'(6'b001111), `WB_MODE_FIQ, `WB_PHY_FIQ_R14,
                       `WB_PHY_FIQ_SPSR, `WB_VEC_FIQ, 1'b1, 32'h0000_0608);
        take_exception("irq over swi", exc_t'(6'b000111), `WB_MODE_IRQ, `WB_PHY_IRQ_R14,
                       `WB_PHY_IRQ_SPSR, `WB_VEC_IRQ, 1'b0, 32'h0000_0708);
        take_exception("dabt over all", exc_t'(6'b011111), `WB_MODE_ABT, `WB_PHY_ABT_R14,
                       `WB_PHY_ABT_SPSR, `WB_VEC_DABT, 1'b0, 32'h0000_0808);
end
endtask

task automatic test_stall_shelve();
begin
        tick();
        i_code_stall <= 1'b1;
        settle();
        expect_advance("stall entry", 32'd4);
        tick();
        i_clear_from_decode <= 1'b1;
        i_pc_from_decode    <= 32'h0000_0400;
        settle();
        expect_hold("stall hold", 1'b0);
        // A second clear replaces the shelved target.
        tick();
        i_pc_from_decode <= 32'h0000_0500;
        settle();
        expect_hold("stall shelve", 1'b1);
        tick();
        i_clear_from_decode <= 1'b0;
        i_code_stall        <= 1'b0;
        settle();
        expect_hold("stall replace", 1'b1);
        tick();
        settle();
        expect_jump("stall release", 32'h0000_0500);
        check_bit("stall release o_shelve", 1'b0, o_shelve);
        tick();
        settle();
        expect_advance("after release", 32'd4);
end
endtask

task automatic test_dabt_restart();
begin
        tick();
        i_exc        <= exc_t'(6'b100000);
        i_pc_buf_ff  <= 32'h0000_1008;
        i_rd_index_0 <= `WB_PHY_ABT_R14;
        i_rd_index_1 <= `WB_PHY_ABT_SPSR;
        settle();
        expect_advance("dabt restart", 32'd4);
        check_bit("dabt restart o_clear_from_writeback", 1'b1, o_clear_from_writeback);
        check_cpsr("dabt restart o_cpsr_nxt", exp_cpsr, o_cpsr_nxt);
        tick();
        drive_idle();
        settle();
        expect_jump("dabt restart", 32'h0000_1000);
        check_word("dabt restart r14 kept", banked_ret, o_rd_data_0);
        check_word("dabt restart spsr kept", word_t'(banked_spsr), o_rd_data_1);
        check_cpsr("dabt restart cpsr kept", exp_cpsr, o_cpsr_nxt);
        tick();
        settle();
        expect_advance("after restart", 32'd4);
end
endtask

// --------------------------------------------------
// Main sequence
// --------------------------------------------------

initial
begin
        i_reset             = 1'b1;
        i_code_stall        = 1'b0;
        i_clear_from_alu    = 1'b0;
        i_pc_from_alu       = '0;
        i_clear_from_decode = 1'b0;
        i_pc_from_decode    = '0;
        i_clear_from_icache = 1'b0;
        i_thumb             = 1'b0;
        i_pc_buf_ff         = '0;
        i_retire            = '0;
        i_exc               = '0;
        i_rd_index_0        = '0;
        i_rd_index_1        = '0;
        repeat (8) tick();
        i_reset <= 1'b0;
        test_reset_advance();
        test_retire();
        test_load_pc();
        test_exceptions();
        test_stall_shelve();
        test_dabt_restart();
        $display("Simulation passed");
        $finish;
end

endmodule

// ==== rtl/wb_stage_top.sv ====
// --------------------------------------------------
// Writeback stage top level.
// Register file, exception unit and PC sequencer.
// --------------------------------------------------

module wb_stage_top
import wb_pkg::*;
(
        input  logic     i_clk,
        input  logic     i_reset,
        input  logic     i_code_stall,
        input  logic     i_clear_from_alu,
        input  word_t    i_pc_from_alu,
        input  logic     i_clear_from_decode,
        input  word_t    i_pc_from_decode,
        input  logic     i_clear_from_icache,
        input  logic     i_thumb,
        input  word_t    i_pc_buf_ff,
        input  retire_t  i_retire,
        input  exc_t     i_exc,
        input  phy_idx_t i_rd_index_0,
        input  phy_idx_t i_rd_index_1,
        output word_t    o_rd_data_0,
        output word_t    o_rd_data_1,
        output word_t    o_pc,
        output word_t    o_pc_nxt,
        output cpsr_t    o_cpsr_nxt,
        output logic     o_clear_from_writeback,
        output logic     o_shelve,
        output logic     o_mask
);

// Exception unit to register file and sequencer.
logic      wen;
wr_req_t   wr_a;
wr_req_t   wr_b;
redirect_t redirect;

wb_regfile u_regfile (
        .i_clk       (i_clk),
        .i_wen       (wen),
        .i_wr_a      (wr_a),
        .i_wr_b      (wr_b),
        .i_rd_addr_a (i_rd_index_0),
        .i_rd_addr_b (i_rd_index_1),
        .o_rd_data_a (o_rd_data_0),
        .o_rd_data_b (o_rd_data_1)
);

wb_exception_unit u_exception_unit (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_retire    (i_retire),
        .i_exc       (i_exc),
        .i_pc_buf_ff (i_pc_buf_ff),
        .o_wen       (wen),
        .o_wr_a      (wr_a),
        .o_wr_b      (wr_b),
        .o_redirect  (redirect),
        .o_cpsr_nxt  (o_cpsr_nxt),
        .o_clear     (o_clear_from_writeback)
);

wb_pc_sequencer u_pc_sequencer (
        .i_clk               (i_clk),
        .i_reset             (i_reset),
        .i_code_stall        (i_code_stall),
        .i_thumb             (i_thumb),
        .i_clear_from_alu    (i_clear_from_alu),
        .i_pc_from_alu       (i_pc_from_alu),
        .i_clear_from_decode (i_clear_from_decode),
        .i_pc_from_decode    (i_pc_from_decode),
        .i_clear_from_icache (i_clear_from_icache),
        .i_redirect          (redirect),
        .o_pc                (o_pc),
        .o_pc_nxt            (o_pc_nxt),
        .o_shelve            (o_shelve),
        .o_mask              (o_mask)
);

endmodule

// ==== rtl/wb_pc_sequencer.sv ====
// --------------------------------------------------
// Program counter sequencer.
// Advances, holds and redirects the PC. A redirect
// seen under a code stall is shelved until release.
// --------------------------------------------------

module wb_pc_sequencer
import wb_pkg::*;
(
        // Clock and reset.
        input  logic      i_clk,
        input  logic      i_reset,

        // Flow control.
        input  logic      i_code_stall,
        input  logic      i_thumb,

        // Low priority clears.
        input  logic      i_clear_from_alu,
        input  word_t     i_pc_from_alu,
        input  logic      i_clear_from_decode,
        input  word_t     i_pc_from_decode,
        input  logic      i_clear_from_icache,

        // Writeback redirect, highest priority.
        input  redirect_t i_redirect,

        // PC outputs and status.
        output word_t     o_pc,
        output word_t     o_pc_nxt,
        output logic      o_shelve,
        output logic      o_mask
);

// --------------------------------------------------
// State
// --------------------------------------------------

word_t pc_ff, pc_nxt;
word_t pc_del_ff, pc_del_nxt;
word_t pc_shelve_ff, pc_shelve_nxt;
logic  shelve_ff, shelve_nxt;
logic  mask_ff, mask_nxt;

// Pending jump from the priority tree.
logic  jump;
word_t jump_tgt;

assign o_pc     = pc_del_ff;
assign o_pc_nxt = pc_ff;
assign o_shelve = shelve_ff;
assign o_mask   = mask_ff;

// --------------------------------------------------
// Priority tree
// --------------------------------------------------

always_comb
begin
        pc_nxt        = pc_ff;
        pc_del_nxt    = pc_del_ff;
        pc_shelve_nxt = pc_shelve_ff;
        shelve_nxt    = shelve_ff;
        mask_nxt      = 1'b0;
        jump          = 1'b0;
        jump_tgt      = pc_ff;

        if (i_redirect.valid)
        begin
                // Writeback overrides everything below.
                jump     = 1'b1;
                jump_tgt = i_redirect.target;
        end
        else if (i_clear_from_alu)
        begin
                jump     = 1'b1;
                jump_tgt = i_pc_from_alu;
        end
        else if (i_clear_from_decode)
        begin
                jump     = 1'b1;
                jump_tgt = i_pc_from_decode;
        end
        else if (i_code_stall)
        begin
                // Hold both PCs.
        end
        else if (shelve_ff)
        begin
                // Stall is over, apply the stored target.
                pc_nxt     = pc_shelve_ff;
                pc_del_nxt = pc_ff;
                shelve_nxt = 1'b0;
                mask_nxt   = 1'b1;
        end
        else if (i_clear_from_icache)
        begin
                // Refetch from the delayed PC.
                jump     = 1'b1;
                jump_tgt = pc_del_ff;
        end
        else
        begin
                pc_nxt     = pc_ff + (i_thumb ? 32'd2 : 32'd4);
                pc_del_nxt = pc_ff;
        end

        // Jump now, or park the target under a stall.
        if (jump && !i_code_stall)
        begin
                pc_nxt     = jump_tgt;
                pc_del_nxt = pc_ff;
                shelve_nxt = 1'b0;
                mask_nxt   = 1'b1;
        end
        else if (jump)
        begin
                pc_shelve_nxt = jump_tgt;
                shelve_nxt    = 1'b1;
        end

        // Bit 0 of the PC is never set.
        pc_nxt[0] = 1'b0;
end

// --------------------------------------------------
// Registers
// --------------------------------------------------

always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                pc_ff     <= '0;
                pc_del_ff <= '0;
                shelve_ff <= 1'b0;
                mask_ff   <= 1'b0;
        end
        else
        begin
                pc_ff     <= pc_nxt;
                pc_del_ff <= pc_del_nxt;
                shelve_ff <= shelve_nxt;
                mask_ff   <= mask_nxt;
        end
end

// Stored target of a shelved redirect.
always_ff @(posedge i_clk)
begin
        pc_shelve_ff <= pc_shelve_nxt;
end

endmodule

// ==== rtl/wb_exception_unit.sv ====
// --------------------------------------------------
// Writeback exception unit.
// Holds the CPSR, ranks exception requests against
// the retiring instruction and produces register
// writes and PC redirect requests.
// --------------------------------------------------

`include "wb_config.svh"

module wb_exception_unit
import wb_pkg::*;
(
        // Clock and reset.
        input  logic      i_clk,
        input  logic      i_reset,

        // Retiring instruction and exception requests.
        input  retire_t   i_retire,
        input  exc_t      i_exc,

        // PC + 8 of the instruction at writeback.
        input  word_t     i_pc_buf_ff,

        // Register file writes.
        output logic      o_wen,
        output wr_req_t   o_wr_a,
        output wr_req_t   o_wr_b,

        // PC change and pipeline flush.
        output redirect_t o_redirect,
        output cpsr_t     o_cpsr_nxt,
        output logic      o_clear
);

// --------------------------------------------------
// State and selection
// --------------------------------------------------

cpsr_t      cpsr_ff;
cpsr_t      cpsr_nxt;

// Selected exception, if any.
logic       exc_take;
logic [4:0] exc_mode;
phy_idx_t   exc_r14;
phy_idx_t   exc_spsr;
word_t      exc_vec;
logic       exc_set_f;

// Link register value.
word_t      ret_addr;

assign o_cpsr_nxt = cpsr_nxt;

// Thumb data aborts link one halfword pair further.
assign ret_addr = (i_exc.dabt && cpsr_ff.t) ? i_pc_buf_ff + 32'd4 : i_pc_buf_ff;

// Exception priority. Restart is handled separately.
always_comb
begin
        exc_take  = 1'b1;
        exc_set_f = 1'b0;
        exc_mode  = `WB_MODE_UND;
        exc_r14   = `WB_PHY_UND_R14;
        exc_spsr  = `WB_PHY_UND_SPSR;
        exc_vec   = `WB_VEC_UND;

        if (i_exc.dabt)
        begin
                exc_mode  = `WB_MODE_ABT;
                exc_r14   = `WB_PHY_ABT_R14;
                exc_spsr  = `WB_PHY_ABT_SPSR;
                exc_vec   = `WB_VEC_DABT;
        end
        else if (i_exc.fiq)
        begin
                // FIQ also masks further FIQs.
                exc_mode  = `WB_MODE_FIQ;
                exc_r14   = `WB_PHY_FIQ_R14;
                exc_spsr  = `WB_PHY_FIQ_SPSR;
                exc_vec   = `WB_VEC_FIQ;
                exc_set_f = 1'b1;
        end
        else if (i_exc.irq)
        begin
                exc_mode  = `WB_MODE_IRQ;
                exc_r14   = `WB_PHY_IRQ_R14;
                exc_spsr  = `WB_PHY_IRQ_SPSR;
                exc_vec   = `WB_VEC_IRQ;
        end
        else if (i_exc.swi)
        begin
                exc_mode  = `WB_MODE_SVC;
                exc_r14   = `WB_PHY_SVC_R14;
                exc_spsr  = `WB_PHY_SVC_SPSR;
                exc_vec   = `WB_VEC_SWI;
        end
        else if (!i_exc.und)
        begin
                // Nothing pending.
                exc_take  = 1'b0;
        end
end

// --------------------------------------------------
// Writes, status and redirects
// --------------------------------------------------

always_comb
begin
        cpsr_nxt   = cpsr_ff;
        o_wen      = 1'b0;
        o_wr_a     = '{idx: `WB_PHY_RAZ, data: '0};
        o_wr_b     = '{idx: `WB_PHY_RAZ, data: '0};
        o_redirect = '0;
        o_clear    = 1'b0;

        if (i_exc.dabt_restart)
        begin
                // Back to the aborted instruction itself.
                o_redirect.valid  = 1'b1;
                o_redirect.target = cpsr_ff.t ? i_pc_buf_ff - 32'd4 : i_pc_buf_ff - 32'd8;
                o_clear           = 1'b1;
        end
        else if (exc_take)
        begin
                // Bank the link register and the old status.
                o_wen             = 1'b1;
                o_wr_a            = '{idx: exc_r14, data: ret_addr};
                o_wr_b            = '{idx: exc_spsr, data: cpsr_ff};
                cpsr_nxt.mode     = exc_mode;
                cpsr_nxt.i        = 1'b1;
                cpsr_nxt.t        = 1'b0;
                cpsr_nxt.f        = cpsr_ff.f | exc_set_f;
                o_redirect.valid  = 1'b1;
                o_redirect.target = exc_vec;
                o_clear           = 1'b1;
        end
        else if (i_retire.valid)
        begin
                cpsr_nxt = i_retire.flags;
                o_wen    = 1'b1;
                o_wr_a   = i_retire.alu_wr;
                if (i_retire.mem_load)
                begin
                        o_wr_b = i_retire.mem_wr;
                end

                // A load into the PC is a jump.
                if (i_retire.mem_load && i_retire.mem_wr.idx == `WB_PHY_PC)
                begin
                        o_redirect.valid  = 1'b1;
                        o_redirect.target = i_retire.mem_wr.data;
                        o_clear           = 1'b1;
                end
        end
end

// Supervisor mode, interrupts masked, ARM state.
always_ff @(posedge i_clk)
begin
        if (i_reset)
        begin
                cpsr_ff <= '{i: 1'b1, f: 1'b1, t: 1'b0, mode: `WB_MODE_SVC, default: '0};
        end
        else
        begin
                cpsr_ff <= cpsr_nxt;
        end
end

endmodule

// ==== rtl/wb_regfile.sv ====
// --------------------------------------------------
// Banked physical register file.
// Two write ports sharing one enable and two
// combinational read ports.
// --------------------------------------------------

`include "wb_config.svh"

module wb_regfile
import wb_pkg::*;
(
        // Clock.
        input  logic     i_clk,

        // Write side.
        input  logic     i_wen,
        input  wr_req_t  i_wr_a,
        input  wr_req_t  i_wr_b,

        // Read addresses.
        input  phy_idx_t i_rd_addr_a,
        input  phy_idx_t i_rd_addr_b,

        // Read data.
        output word_t    o_rd_data_a,
        output word_t    o_rd_data_b
);

// --------------------------------------------------
// Storage
// --------------------------------------------------

// Register contents, no reset.
word_t mem [`WB_PHY_REGS];

// Discard checks for each write port.
logic  keep_a;
logic  keep_b;

assign keep_a = (i_wr_a.idx != `WB_PHY_RAZ);
assign keep_b = (i_wr_b.idx != `WB_PHY_RAZ);

// --------------------------------------------------
// Write
// --------------------------------------------------

// Port b is written last so it wins on a collision.
always_ff @(posedge i_clk)
begin
        if (i_wen)
        begin
                if (keep_a)
                begin
                        mem[i_wr_a.idx] <= i_wr_a.data;
                end
                if (keep_b)
                begin
                        mem[i_wr_b.idx] <= i_wr_b.data;
                end
        end
end

// --------------------------------------------------
// Read
// --------------------------------------------------

// Straight from the array, no bypass.
assign o_rd_data_a = mem[i_rd_addr_a];
assign o_rd_data_b = mem[i_rd_addr_b];

endmodule

// ==== rtl/wb_pkg.sv ====
// --------------------------------------------------
// Writeback stage types.
// Packed structs for register writes, retiring
// instructions, exception requests and redirects.
// --------------------------------------------------

`include "wb_config.svh"

package wb_pkg;

        // --------------------------------------------------
        // Basic words and indices
        // --------------------------------------------------

        // One data word or PC value.
        typedef logic [`WB_WORD_W-1:0] word_t;

        // Index into the physical register file.
        typedef logic [$clog2(`WB_PHY_REGS)-1:0] phy_idx_t;

        // Status register layout, ARM bit positions.
        typedef struct packed {
                logic        n;
                logic        z;
                logic        c;
                logic        v;
                logic [19:0] rsvd;
                logic        i;      // IRQ mask.
                logic        f;      // FIQ mask.
                logic        t;      // Thumb state.
                logic [4:0]  mode;
        } cpsr_t;

        // --------------------------------------------------
        // Stage payloads
        // --------------------------------------------------

        // A single register write.
        typedef struct packed {
                phy_idx_t idx;
                word_t    data;
        } wr_req_t;

        // Instruction leaving the memory stage.
        typedef struct packed {
                logic    valid;
                wr_req_t alu_wr;     // Result from the ALU side.
                cpsr_t   flags;      // Status after this instruction.
                logic    mem_load;   // Memory port carries load data.
                wr_req_t mem_wr;     // Result from the memory side.
        } retire_t;

        // Exception requests, highest priority first.
        typedef struct packed {
                logic dabt_restart;
                logic dabt;
                logic fiq;
                logic irq;
                logic swi;
                logic und;
        } exc_t;

        // PC change request.
        typedef struct packed {
                logic  valid;
                word_t target;
        } redirect_t;

endpackage

// ==== rtl/wb_config.svh ====
// --------------------------------------------------
// Writeback stage configuration.
// Widths, register count, exception vectors, mode
// codes and the banked physical register map.
// --------------------------------------------------

`ifndef WB_CONFIG_SVH
`define WB_CONFIG_SVH

// Data and PC width.
`define WB_WORD_W       32

// Number of physical registers in the banked file.
`define WB_PHY_REGS     46

// Exception vectors.
`define WB_VEC_UND      32'h0000_0004
`define WB_VEC_SWI      32'h0000_0008
`define WB_VEC_DABT     32'h0000_0010
`define WB_VEC_IRQ      32'h0000_0018
`define WB_VEC_FIQ      32'h0000_001C

// Processor mode codes, CPSR[4:0].
`define WB_MODE_FIQ     5'h11
`define WB_MODE_IRQ     5'h12
`define WB_MODE_SVC     5'h13
`define WB_MODE_ABT     5'h17
`define WB_MODE_UND     5'h1B

// Architectural PC and the write-discard slot.
`define WB_PHY_PC       6'd15
`define WB_PHY_RAZ      6'd16

// Banked link registers.
`define WB_PHY_FIQ_R14  6'd23
`define WB_PHY_IRQ_R14  6'd25
`define WB_PHY_SVC_R14  6'd27
`define WB_PHY_UND_R14  6'd29
`define WB_PHY_ABT_R14  6'd31

// Saved status registers.
`define WB_PHY_FIQ_SPSR 6'd32
`define WB_PHY_IRQ_SPSR 6'd33
`define WB_PHY_SVC_SPSR 6'd34
`define WB_PHY_UND_SPSR 6'd35
`define WB_PHY_ABT_SPSR 6'd36

`endif
